// ==== Makefile ====
# Verilator flow for the AXI4-Lite register slave

VERILATOR  ?= verilator
TOP        ?= axi_regs_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+logic
logic/axi_regs_pkg.sv
logic/axi_chan_slice.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/axi_reg_bank.sv
logic/axi_regs_top.sv
testbench/axi_regs_properties.sv
testbench/axi_regs_tb.sv

// ==== logic/axi_chan_slice.sv ====
// one-entry channel buffer; accepts only when empty, so at most one entry every two cycles
`timescale 1ns/1ps

module axi_chan_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    // upstream side
    input  payload_t in,
    input  logic     in_valid,
    output logic     in_ready,

    // downstream side
    output payload_t out,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     full;
    payload_t data_q;

    // ready comes from state only, never from in_valid
    assign in_ready  = !full;
    assign out_valid = full;
    assign out       = data_q;

    // push and pop never overlap since a push needs an empty slice
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_valid && out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in;
        end
    end

endmodule

// ==== logic/axi_read_engine.sv ====
// reads the 16 x 32-bit bank; a miss returns zero data with SLVERR and skips the bank
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                      clk,
    input  logic                      rst,

    // address entries from the AR slice
    input  axi_regs_pkg::addr_chan_t  ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,

    // bank read port, data one cycle after rd_en
    output logic                      rd_en,
    output logic [3:0]                rd_index,
    input  logic [31:0]               rd_data,

    // read response
    output axi_regs_pkg::rdata_chan_t r,
    output logic                      r_valid,
    input  logic                      r_ready
);

    logic                  pop;
    logic                  hit_q;
    logic                  r_valid_q;
    axi_regs_pkg::decode_t dec;

    // R hold is free, or frees up in this cycle
    assign ar_ready = !r_valid_q || r_ready;
    assign pop      = ar_valid && ar_ready;

    assign dec      = axi_regs_pkg::addr_decode(ar.addr);
    assign rd_en    = pop && dec.hit;
    assign rd_index = dec.index;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
        end else if (pop) begin
            r_valid_q <= 1'b1;
        end else if (r_ready) begin
            r_valid_q <= 1'b0;
        end
    end

    // hit flag travels alongside the bank access
    always_ff @(posedge clk) begin
        if (pop) begin
            hit_q <= dec.hit;
        end
    end

    // rd_data only moves on the next pop, so it stays put while R is held
    assign r_valid = r_valid_q;
    assign r.data  = hit_q ? rd_data : 32'h0;
    assign r.resp  = hit_q ? axi_regs_pkg::RESP_OKAY : axi_regs_pkg::RESP_SLVERR;

endmodule

// ==== logic/axi_reg_bank.sv ====
// plain storage with no side effects; index is trusted, the engines do the address check
`timescale 1ns/1ps
`include "axi_regs_cfg.svh"

module axi_reg_bank (
    input  logic                   clk,
    input  logic                   rst,

    // write port with byte strobes
    input  logic                   wr_en,
    input  axi_regs_pkg::reg_wr_t  wr,

    // registered read port
    input  logic                   rd_en,
    input  logic [`AXI_IDX_W-1:0]  rd_index,
    output logic [`AXI_DATA_W-1:0] rd_data
);

    logic [`AXI_DATA_W-1:0] regs_q [`AXI_REGS_COUNT];
    logic [`AXI_DATA_W-1:0] byte_mask;

    // expand each strobe bit over its byte lane
    always_comb begin
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            byte_mask[8*i +: 8] = {8{wr.strb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `AXI_REGS_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr.index] <= (regs_q[wr.index] & ~byte_mask) | (wr.data & byte_mask);
        end
    end

    // a read in the same cycle as a write sees the old word
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= regs_q[rd_index];
        end
    end

endmodule

// ==== logic/axi_regs_cfg.svh ====
// register window geometry; changing the data width also changes the strobe width
`ifndef AXI_REGS_CFG_SVH
`define AXI_REGS_CFG_SVH

// byte address of register 0
`define AXI_REGS_BASE 32'h4000_0000

// number of 32-bit registers in the window
`define AXI_REGS_COUNT 16

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// register index width, derived from the count
`define AXI_IDX_W $clog2(`AXI_REGS_COUNT)

`endif

// ==== logic/axi_regs_pkg.sv ====
// channel payloads and address decode for a 16 x 32-bit AXI4-Lite window; no PROT, IDs or bursts
`include "axi_regs_cfg.svh"

package axi_regs_pkg;

    // AW or AR payload
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } addr_chan_t;

    // W payload
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
    } wdata_chan_t;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        resp_e resp;
    } bresp_chan_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
    } rdata_chan_t;

    typedef struct packed {
        logic                  hit;
        logic [`AXI_IDX_W-1:0] index;
    } decode_t;

    // single-cycle write request into the register bank
    typedef struct packed {
        logic [`AXI_IDX_W-1:0]  index;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
    } reg_wr_t;

    // hit needs a word-aligned address inside the window
    function automatic decode_t addr_decode(input logic [`AXI_ADDR_W-1:0] addr);
        logic [`AXI_ADDR_W-1:0] offset;
        decode_t                dec;
        offset    = addr - `AXI_REGS_BASE;
        dec.hit   = (addr >= `AXI_REGS_BASE)
                  && (offset < `AXI_ADDR_W'(`AXI_REGS_COUNT * `AXI_STRB_W))
                  && (addr[1:0] == 2'b00);
        dec.index = offset[`AXI_IDX_W+1:2];
        return dec;
    endfunction

endpackage

// ==== logic/axi_regs_top.sv ====
// AXI4-Lite slave at 0x4000_0000, 16 words; single outstanding response per direction
`timescale 1ns/1ps

module axi_regs_top (
    input  logic                      clk,
    input  logic                      rst,

    input  axi_regs_pkg::addr_chan_t  aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,

    input  axi_regs_pkg::wdata_chan_t w,
    input  logic                      w_valid,
    output logic                      w_ready,

    output axi_regs_pkg::bresp_chan_t b,
    output logic                      b_valid,
    input  logic                      b_ready,

    input  axi_regs_pkg::addr_chan_t  ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,

    output axi_regs_pkg::rdata_chan_t r,
    output logic                      r_valid,
    input  logic                      r_ready
);

    // slice outputs toward the engines
    axi_regs_pkg::addr_chan_t  aw_buf;
    logic                      aw_buf_valid;
    logic                      aw_buf_ready;
    axi_regs_pkg::wdata_chan_t w_buf;
    logic                      w_buf_valid;
    logic                      w_buf_ready;
    axi_regs_pkg::addr_chan_t  ar_buf;
    logic                      ar_buf_valid;
    logic                      ar_buf_ready;

    // bank ports
    logic                      wr_en;
    axi_regs_pkg::reg_wr_t     wr;
    logic                      rd_en;
    logic [3:0]                rd_index;
    logic [31:0]               rd_data;

    axi_chan_slice #(
        .payload_t (axi_regs_pkg::addr_chan_t)
    ) u_aw_slice (
        .clk       (clk),
        .rst       (rst),
        .in        (aw),
        .in_valid  (aw_valid),
        .in_ready  (aw_ready),
        .out       (aw_buf),
        .out_valid (aw_buf_valid),
        .out_ready (aw_buf_ready)
    );

    axi_chan_slice #(
        .payload_t (axi_regs_pkg::wdata_chan_t)
    ) u_w_slice (
        .clk       (clk),
        .rst       (rst),
        .in        (w),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .out       (w_buf),
        .out_valid (w_buf_valid),
        .out_ready (w_buf_ready)
    );

    axi_chan_slice #(
        .payload_t (axi_regs_pkg::addr_chan_t)
    ) u_ar_slice (
        .clk       (clk),
        .rst       (rst),
        .in        (ar),
        .in_valid  (ar_valid),
        .in_ready  (ar_ready),
        .out       (ar_buf),
        .out_valid (ar_buf_valid),
        .out_ready (ar_buf_ready)
    );

    axi_write_engine u_write_engine (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw_buf),
        .aw_valid (aw_buf_valid),
        .aw_ready (aw_buf_ready),
        .w        (w_buf),
        .w_valid  (w_buf_valid),
        .w_ready  (w_buf_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_en    (wr_en),
        .wr       (wr)
    );

    axi_read_engine u_read_engine (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar_buf),
        .ar_valid (ar_buf_valid),
        .ar_ready (ar_buf_ready),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    axi_reg_bank u_reg_bank (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr       (wr),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

// ==== logic/axi_write_engine.sv ====
// pairs one AW entry with one W entry; a miss writes nothing and answers SLVERR
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                      clk,
    input  logic                      rst,

    // address entries from the AW slice
    input  axi_regs_pkg::addr_chan_t  aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,

    // data entries from the W slice
    input  axi_regs_pkg::wdata_chan_t w,
    input  logic                      w_valid,
    output logic                      w_ready,

    // write response
    output axi_regs_pkg::bresp_chan_t b,
    output logic                      b_valid,
    input  logic                      b_ready,

    // bank write port
    output logic                      wr_en,
    output axi_regs_pkg::reg_wr_t     wr
);

    logic                    pop;
    axi_regs_pkg::decode_t   dec;
    axi_regs_pkg::resp_e     resp_q;
    logic                    b_valid_q;

    // both entries leave together, and only once the B hold is free
    assign pop = aw_valid && w_valid && !b_valid_q;

    // each side is ready when the other side has its entry
    assign aw_ready = w_valid && !b_valid_q;
    assign w_ready  = aw_valid && !b_valid_q;

    // address rule shared with the read side
    assign dec = axi_regs_pkg::addr_decode(aw.addr);

    // bank write in the pop cycle
    assign wr_en    = pop && dec.hit;
    assign wr.index = dec.index;
    assign wr.data  = w.data;
    assign wr.strb  = w.strb;

    // B hold, set by a pop and cleared by the handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid_q <= 1'b0;
        end else if (pop) begin
            b_valid_q <= 1'b1;
        end else if (b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    // response code captured with the pop, stable while held
    always_ff @(posedge clk) begin
        if (pop) begin
            if (dec.hit) begin
                resp_q <= axi_regs_pkg::RESP_OKAY;
            end else begin
                resp_q <= axi_regs_pkg::RESP_SLVERR;
            end
        end
    end

    assign b_valid = b_valid_q;
    assign b.resp  = resp_q;

endmodule

// ==== testbench/axi_regs_properties.sv ====
// B and R handshake rules only; transfer counters assume fewer than 2^31 transfers per run
`timescale 1ns/1ps

module axi_regs_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      aw_valid,
    input logic                      aw_ready,
    input logic                      w_valid,
    input logic                      w_ready,
    input axi_regs_pkg::bresp_chan_t b,
    input logic                      b_valid,
    input logic                      b_ready,
    input axi_regs_pkg::rdata_chan_t r,
    input logic                      r_valid,
    input logic                      r_ready
);

    // transfers seen so far on each write channel
    int aw_count;
    int w_count;
    int b_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_count <= 0;
            w_count  <= 0;
            b_count  <= 0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_count <= aw_count + 1;
            end
            if (w_valid && w_ready) begin
                w_count <= w_count + 1;
            end
            if (b_valid && b_ready) begin
                b_count <= b_count + 1;
            end
        end
    end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("B response dropped or changed while b_ready was low");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R response dropped or changed while r_ready was low");

    reset_idle: assert property (@(posedge clk) rst |=> !b_valid && !r_valid)
        else $error("response valid high during reset");

    // every new B needs its own AW and W transfer
    b_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(b_valid) |-> (aw_count > b_count) && (w_count > b_count))
        else $error("B response without a matching AW and W pair");

endmodule

// ==== testbench/axi_regs_tb.sv ====
// one stream of writes or reads at a time; responses are expected in issue order
`timescale 1ns/1ps
`include "axi_regs_cfg.svh"

module axi_regs_tb;

    localparam int N_BASIC  = 24;
    localparam int N_BAD    = 8;
    localparam int N_STREAM = 40;
    // every read and write issued by the sequence below
    localparam int N_TXN    = 16 + 2 * N_BASIC + N_BAD + 16 + N_BAD + 2 * N_STREAM;

    // one planned transaction with its gaps and stall
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  gap_a;
        logic [1:0]  gap_b;
        logic [1:0]  stall;
    } txn_t;

    logic                      clk = 1'b0;
    logic                      rst;
    axi_regs_pkg::addr_chan_t  aw;
    logic                      aw_valid;
    logic                      aw_ready;
    axi_regs_pkg::wdata_chan_t w;
    logic                      w_valid;
    logic                      w_ready;
    axi_regs_pkg::bresp_chan_t b;
    logic                      b_valid;
    logic                      b_ready;
    axi_regs_pkg::addr_chan_t  ar;
    logic                      ar_valid;
    logic                      ar_ready;
    axi_regs_pkg::rdata_chan_t r;
    logic                      r_valid;
    logic                      r_ready;

    logic [31:0]               model [16];
    logic [31:0]               seed = 32'h2afb07c7;
    txn_t                      wq[$];
    txn_t                      rq[$];
    axi_regs_pkg::resp_e       b_exp[$];
    axi_regs_pkg::rdata_chan_t r_exp[$];
    int                        n_checks;
    int                        n_errors;
    int                        gap_max;
    int                        stall_max;

    axi_regs_top u_axi_regs_top (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    bind axi_regs_top axi_regs_properties u_props (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper bits only since the low bits of an LCG cycle quickly
    function automatic int rand_below(input int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[31:16]) % n;
    endfunction

    // word aligned and inside the 64-byte window
    function automatic logic addr_hit(input logic [31:0] a);
        return (a >= `AXI_REGS_BASE) && (a <= `AXI_REGS_BASE + 32'h3C) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [31:0] good_addr();
        return `AXI_REGS_BASE + 32'(4 * rand_below(16));
    endfunction

    function automatic logic [31:0] bad_addr();
        logic [31:0] a;
        case (rand_below(4))
            0: a = good_addr() + 32'(1 + rand_below(3));
            1: a = `AXI_REGS_BASE - 32'(4 + 4 * rand_below(64));
            2: a = `AXI_REGS_BASE + 32'h40 + 32'(4 * rand_below(64));
            // odd, so never aligned
            default: a = lcg_next() | 32'h1;
        endcase
        return a;
    endfunction

    function automatic txn_t make_txn(input logic [31:0] addr);
        txn_t t;
        t.addr  = addr;
        t.data  = lcg_next();
        t.strb  = (rand_below(2) == 0) ? 4'hf : 4'(rand_below(16));
        t.gap_a = 2'(rand_below(gap_max + 1));
        t.gap_b = 2'(rand_below(gap_max + 1));
        t.stall = 2'(rand_below(stall_max + 1));
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // model update once both halves of the write are handed over
    task automatic model_write(input txn_t t);
        logic [31:0] off;
        off = t.addr - `AXI_REGS_BASE;
        if (addr_hit(t.addr)) begin
            for (int k = 0; k < 4; k++) begin
                if (t.strb[k]) begin
                    model[off[5:2]][8*k +: 8] = t.data[8*k +: 8];
                end
            end
            b_exp.push_back(axi_regs_pkg::RESP_OKAY);
        end else begin
            b_exp.push_back(axi_regs_pkg::RESP_SLVERR);
        end
    endtask

    task automatic model_read(input txn_t t);
        logic [31:0]               off;
        axi_regs_pkg::rdata_chan_t e;
        off = t.addr - `AXI_REGS_BASE;
        if (addr_hit(t.addr)) begin
            e.data = model[off[5:2]];
            e.resp = axi_regs_pkg::RESP_OKAY;
        end else begin
            e.data = 32'h0;
            e.resp = axi_regs_pkg::RESP_SLVERR;
        end
        r_exp.push_back(e);
    endtask

    task automatic send_aw(input logic [31:0] addr, input int gap);
        repeat (gap + 1) @(posedge clk);
        #1;
        aw.addr  = addr;
        aw_valid = 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);
        #1;
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input int gap);
        repeat (gap + 1) @(posedge clk);
        #1;
        w.data  = data;
        w.strb  = strb;
        w_valid = 1'b1;
        @(negedge clk);
        while (!w_ready) @(negedge clk);
        @(posedge clk);
        #1;
        w_valid = 1'b0;
    endtask

    task automatic send_ar(input logic [31:0] addr, input int gap);
        repeat (gap + 1) @(posedge clk);
        #1;
        ar.addr  = addr;
        ar_valid = 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        #1;
        ar_valid = 1'b0;
    endtask

    // hold b_ready low for a while and watch that the response stays put
    task automatic take_b(input int stall);
        axi_regs_pkg::bresp_chan_t held;
        @(negedge clk);
        while (!b_valid) @(negedge clk);
        held = b;
        repeat (stall) begin
            @(negedge clk);
            check_value("b_valid", 32'(b_valid), 32'd1);
            check_value("b.resp", 32'(b.resp), 32'(held.resp));
        end
        @(posedge clk);
        #1;
        b_ready = 1'b1;
        @(negedge clk);
        check_value("b.resp", 32'(b.resp), 32'(held.resp));
        @(posedge clk);
        #1;
        b_ready = 1'b0;
        if (b_exp.size() == 0) begin
            report_error("B response arrived with no write outstanding");
        end else begin
            check_value("b.resp", 32'(held.resp), 32'(b_exp.pop_front()));
        end
    endtask

    task automatic take_r(input int stall);
        axi_regs_pkg::rdata_chan_t held;
        axi_regs_pkg::rdata_chan_t e;
        @(negedge clk);
        while (!r_valid) @(negedge clk);
        held = r;
        repeat (stall) begin
            @(negedge clk);
            check_value("r_valid", 32'(r_valid), 32'd1);
            check_value("r.data", r.data, held.data);
            check_value("r.resp", 32'(r.resp), 32'(held.resp));
        end
        @(posedge clk);
        #1;
        r_ready = 1'b1;
        @(negedge clk);
        check_value("r.data", r.data, held.data);
        @(posedge clk);
        #1;
        r_ready = 1'b0;
        if (r_exp.size() == 0) begin
            report_error("R response arrived with no read outstanding");
        end else begin
            e = r_exp.pop_front();
            check_value("r.data", held.data, e.data);
            check_value("r.resp", 32'(held.resp), 32'(e.resp));
        end
    endtask

    // no extra response after the last one is taken
    task automatic drain_check();
        repeat (4) @(negedge clk);
        check_value("b_valid", 32'(b_valid), 32'd0);
        check_value("r_valid", 32'(r_valid), 32'd0);
    endtask

    task automatic do_writes();
        fork
            begin
                foreach (wq[i]) begin
                    fork
                        send_aw(wq[i].addr, int'(wq[i].gap_a));
                        send_w(wq[i].data, wq[i].strb, int'(wq[i].gap_b));
                    join
                    model_write(wq[i]);
                end
            end
            begin
                foreach (wq[i]) take_b(int'(wq[i].stall));
            end
        join
        drain_check();
        wq.delete();
    endtask

    task automatic do_reads();
        fork
            begin
                foreach (rq[i]) begin
                    send_ar(rq[i].addr, int'(rq[i].gap_a));
                    model_read(rq[i]);
                end
            end
            begin
                foreach (rq[i]) take_r(int'(rq[i].stall));
            end
        join
        drain_check();
        rq.delete();
    endtask

    initial begin
        repeat (400 * N_TXN) @(posedge clk);
        $display("timeout: a handshake or response did not complete in %0d cycles", 400 * N_TXN);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        rst       = 1'b1;
        aw        = '0;
        aw_valid  = 1'b0;
        w         = '0;
        w_valid   = 1'b0;
        b_ready   = 1'b0;
        ar        = '0;
        ar_valid  = 1'b0;
        r_ready   = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        gap_max   = 0;
        stall_max = 0;
        for (int i = 0; i < 16; i++) begin
            model[i] = 32'h0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle state right after reset
        @(negedge clk);
        check_value("aw_ready", 32'(aw_ready), 32'd1);
        check_value("w_ready", 32'(w_ready), 32'd1);
        check_value("ar_ready", 32'(ar_ready), 32'd1);
        check_value("b_valid", 32'(b_valid), 32'd0);
        check_value("r_valid", 32'(r_valid), 32'd0);
        for (int i = 0; i < 16; i++) begin
            rq.push_back(make_txn(`AXI_REGS_BASE + 32'(4 * i)));
        end
        do_reads();

        // write then read back, one register at a time
        for (int i = 0; i < N_BASIC; i++) begin
            a = good_addr();
            wq.push_back(make_txn(a));
            do_writes();
            rq.push_back(make_txn(a));
            do_reads();
        end

        // misses must leave every register alone
        for (int i = 0; i < N_BAD; i++) begin
            wq.push_back(make_txn(bad_addr()));
        end
        do_writes();
        for (int i = 0; i < 16; i++) begin
            rq.push_back(make_txn(`AXI_REGS_BASE + 32'(4 * i)));
        end
        for (int i = 0; i < N_BAD; i++) begin
            rq.push_back(make_txn(bad_addr()));
        end
        do_reads();

        // AW and W skewed both ways, responses stalled
        gap_max   = 3;
        stall_max = 3;
        for (int i = 0; i < N_STREAM; i++) begin
            wq.push_back(make_txn((rand_below(5) == 0) ? bad_addr() : good_addr()));
        end
        do_writes();
        for (int i = 0; i < N_STREAM; i++) begin
            rq.push_back(make_txn((rand_below(5) == 0) ? bad_addr() : good_addr()));
        end
        do_reads();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
